// File: logic/lane_status.sv
`timescale 1ns/1ps

module lane_status (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      i_load,
	input  logic                      i_linkspeed_exit,
	input  logic                      i_repair_exit,
	input  logic                      i_finish,
	input  mbtrain_pkg::lane_halves_t i_tx_lanes_mbinit,
	input  mbtrain_pkg::lane_halves_t i_rx_lanes_mbinit,
	input  mbtrain_pkg::lane_halves_t i_tx_lanes_linkspeed,
	input  mbtrain_pkg::lane_halves_t i_rx_lanes_repair,
	output mbtrain_pkg::lane_halves_t o_tx_lanes,
	output mbtrain_pkg::lane_halves_t o_rx_lanes,
	output logic                      o_coming_from_repair
);
	import mbtrain_pkg::*;

	logic repair_in_mbinit;
	logic repair_in_train;

	// link speed tells us which tx halves we may send on
	// repair only changes the rx side
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_tx_lanes <= '0;
			o_rx_lanes <= '0;
		end else if (i_load) begin
			o_tx_lanes <= i_tx_lanes_mbinit;
			o_rx_lanes <= i_rx_lanes_mbinit;
		end else if (i_linkspeed_exit) begin
			o_tx_lanes <= i_tx_lanes_linkspeed;
		end else if (i_repair_exit) begin
			o_rx_lanes <= i_rx_lanes_repair;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			repair_in_mbinit <= 1'b0;
			repair_in_train  <= 1'b0;
		end else begin
			// a missing tx half means mbinit already repaired
			if (i_load) begin
				repair_in_mbinit <= (i_tx_lanes_mbinit != LANE_HALVES_ALL);
			end else if (i_finish) begin
				repair_in_mbinit <= 1'b0;
			end
			// fresh mbinit results start a new training history
			if (i_load) begin
				repair_in_train <= 1'b0;
			end else if (i_repair_exit) begin
				repair_in_train <= 1'b1;
			end
		end
	end

	// link speed uses this to avoid a second repair on half width
	assign o_coming_from_repair = repair_in_mbinit | repair_in_train;

endmodule

// File: logic/mbtrain_pkg.sv
package mbtrain_pkg;

	// protocol sizes
	localparam int NUM_SUBSTATES = 13;
	localparam int SUBSTATE_W    = 4;
	localparam int SPEED_W       = 3;
	localparam int LANE_HALVES   = 2;
	localparam int RESOLVED_W    = 2;

	// sideband codes, in training order
	typedef enum logic [SUBSTATE_W-1:0] {
		SS_VALVREF             = 4'd0,
		SS_DATAVREF            = 4'd1,
		SS_SPEED_IDLE          = 4'd2,
		SS_TX_SELFCAL          = 4'd3,
		SS_RX_CLKCAL           = 4'd4,
		SS_VAL_TRAIN_CENTER    = 4'd5,
		SS_VAL_TRAIN_VREF      = 4'd6,
		SS_DATA_TRAIN_CENTER1  = 4'd7,
		SS_DATA_TRAIN_VREF     = 4'd8,
		SS_RX_DESKEW           = 4'd9,
		SS_DATA_TRAIN_CENTER2  = 4'd10,
		SS_LINKSPEED           = 4'd11,
		SS_REPAIR              = 4'd12
	} substate_e;

	// one bit per substate, indexed by substate_e
	typedef logic [NUM_SUBSTATES-1:0] substate_vec_t;

	typedef logic [SPEED_W-1:0] speed_t;

	// bit 0 is lanes 0..7, bit 1 is lanes 8..15
	typedef logic [LANE_HALVES-1:0] lane_halves_t;
	localparam lane_halves_t LANE_HALVES_ALL = '1;

	// phy retrain resolved state
	localparam logic [RESOLVED_W-1:0] RESOLVED_FULL    = 2'd0;
	localparam logic [RESOLVED_W-1:0] RESOLVED_SELFCAL = 2'd1;
	localparam logic [RESOLVED_W-1:0] RESOLVED_REPAIR  = 2'd2;
	localparam logic [RESOLVED_W-1:0] RESOLVED_DEGRADE = 2'd3;

endpackage

// File: logic/mbtrain_sequencer.sv
`timescale 1ns/1ps

module mbtrain_sequencer (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               i_en,
	input  logic [mbtrain_pkg::RESOLVED_W-1:0] i_resolved_state,
	input  logic                               i_retrain_req,
	input  logic                               i_error_req,
	input  logic                               i_degrade_req,
	input  logic                               i_step_done,
	output logic                               o_step_start,
	output mbtrain_pkg::substate_e             o_substate,
	output logic                               o_load_speed,
	output logic                               o_degrade,
	output logic                               o_load_lanes,
	output logic                               o_linkspeed_exit,
	output logic                               o_repair_exit,
	output logic                               o_finish,
	output logic                               o_phyretrain_en,
	output logic                               o_mbtrain_ack
);
	import mbtrain_pkg::*;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_RUN,
		SEQ_FINISH
	} seq_state_e;

	seq_state_e state;
	// launches the entry substate one cycle after leaving idle
	logic       kick;
	substate_e  next_ss;

	// normal order is code + 1, repair goes back to tx self cal
	assign next_ss = (o_substate == SS_REPAIR) ? SS_TX_SELFCAL
		: substate_e'(o_substate + 4'd1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state            <= SEQ_IDLE;
			kick             <= 1'b0;
			o_substate       <= SS_VALVREF;
			o_step_start     <= 1'b0;
			o_load_speed     <= 1'b0;
			o_degrade        <= 1'b0;
			o_load_lanes     <= 1'b0;
			o_linkspeed_exit <= 1'b0;
			o_repair_exit    <= 1'b0;
			o_finish         <= 1'b0;
			o_phyretrain_en  <= 1'b0;
			o_mbtrain_ack    <= 1'b0;
		end else begin
			// event outputs are single cycle pulses
			kick             <= 1'b0;
			o_step_start     <= 1'b0;
			o_load_speed     <= 1'b0;
			o_degrade        <= 1'b0;
			o_load_lanes     <= 1'b0;
			o_linkspeed_exit <= 1'b0;
			o_repair_exit    <= 1'b0;
			o_finish         <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					o_phyretrain_en <= 1'b0;
					o_mbtrain_ack   <= 1'b0;
					if (i_en) begin
						state <= SEQ_RUN;
						kick  <= 1'b1;
						case (i_resolved_state)
							RESOLVED_FULL: begin
								o_substate   <= SS_VALVREF;
								o_load_speed <= 1'b1;
								o_load_lanes <= 1'b1;
							end
							RESOLVED_SELFCAL: o_substate <= SS_TX_SELFCAL;
							RESOLVED_REPAIR:  o_substate <= SS_REPAIR;
							default: begin
								o_substate <= SS_SPEED_IDLE;
								o_degrade  <= 1'b1;
							end
						endcase
					end
				end
				SEQ_RUN: begin
					if (kick) begin
						o_step_start <= 1'b1;
					end else if (i_step_done) begin
						if (o_substate == SS_LINKSPEED) begin
							// request flags only matter at the end of link speed
							o_linkspeed_exit <= 1'b1;
							if (i_retrain_req) begin
								state           <= SEQ_FINISH;
								o_phyretrain_en <= 1'b1;
							end else if (i_error_req && i_degrade_req) begin
								o_substate   <= SS_SPEED_IDLE;
								o_degrade    <= 1'b1;
								o_step_start <= 1'b1;
							end else if (i_error_req) begin
								o_substate   <= SS_REPAIR;
								o_step_start <= 1'b1;
							end else begin
								state <= SEQ_FINISH;
							end
						end else begin
							if (o_substate == SS_REPAIR) begin
								o_repair_exit <= 1'b1;
							end
							o_substate   <= next_ss;
							o_step_start <= 1'b1;
						end
					end
				end
				SEQ_FINISH: begin
					// ack holds until the requester drops i_en
					if (i_en) begin
						o_mbtrain_ack <= 1'b1;
					end else begin
						o_mbtrain_ack <= 1'b0;
						o_finish      <= 1'b1;
						state         <= SEQ_IDLE;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	a_substate_range: assert property (@(posedge clk) disable iff (!rst_n)
		o_substate <= SS_REPAIR);

endmodule

// File: logic/mbtrain_top.sv
`timescale 1ns/1ps

module mbtrain_top (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               i_en,
	input  logic [mbtrain_pkg::RESOLVED_W-1:0] i_resolved_state,
	input  logic                               i_retrain_req,
	input  logic                               i_error_req,
	input  logic                               i_degrade_req,
	input  mbtrain_pkg::speed_t                i_highest_speed,
	input  mbtrain_pkg::lane_halves_t          i_tx_lanes_mbinit,
	input  mbtrain_pkg::lane_halves_t          i_rx_lanes_mbinit,
	input  mbtrain_pkg::lane_halves_t          i_tx_lanes_linkspeed,
	input  mbtrain_pkg::lane_halves_t          i_rx_lanes_repair,
	input  mbtrain_pkg::substate_vec_t         i_substate_ack,
	output mbtrain_pkg::substate_vec_t         o_substate_en,
	output mbtrain_pkg::substate_e             o_sideband_substate,
	output logic                               o_phyretrain_en,
	output logic                               o_mbtrain_ack,
	output mbtrain_pkg::speed_t                o_operating_speed,
	output mbtrain_pkg::lane_halves_t          o_tx_lanes,
	output mbtrain_pkg::lane_halves_t          o_rx_lanes,
	output logic                               o_coming_from_repair
);

	logic step_start;
	logic step_done;
	logic load_speed;
	logic degrade;
	logic load_lanes;
	logic linkspeed_exit;
	logic repair_exit;
	logic finish;

	// the current substate code goes straight to the sideband
	mbtrain_sequencer u_sequencer (
		.clk              (clk),
		.rst_n            (rst_n),
		.i_en             (i_en),
		.i_resolved_state (i_resolved_state),
		.i_retrain_req    (i_retrain_req),
		.i_error_req      (i_error_req),
		.i_degrade_req    (i_degrade_req),
		.i_step_done      (step_done),
		.o_step_start     (step_start),
		.o_substate       (o_sideband_substate),
		.o_load_speed     (load_speed),
		.o_degrade        (degrade),
		.o_load_lanes     (load_lanes),
		.o_linkspeed_exit (linkspeed_exit),
		.o_repair_exit    (repair_exit),
		.o_finish         (finish),
		.o_phyretrain_en  (o_phyretrain_en),
		.o_mbtrain_ack    (o_mbtrain_ack)
	);

	substate_handshake u_handshake (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_step_start (step_start),
		.i_substate   (o_sideband_substate),
		.i_ack        (i_substate_ack),
		.o_en         (o_substate_en),
		.o_step_done  (step_done)
	);

	speed_tracker u_speed (
		.clk             (clk),
		.rst_n           (rst_n),
		.i_load          (load_speed),
		.i_degrade       (degrade),
		.i_highest_speed (i_highest_speed),
		.o_speed         (o_operating_speed)
	);

	lane_status u_lanes (
		.clk                  (clk),
		.rst_n                (rst_n),
		.i_load               (load_lanes),
		.i_linkspeed_exit     (linkspeed_exit),
		.i_repair_exit        (repair_exit),
		.i_finish             (finish),
		.i_tx_lanes_mbinit    (i_tx_lanes_mbinit),
		.i_rx_lanes_mbinit    (i_rx_lanes_mbinit),
		.i_tx_lanes_linkspeed (i_tx_lanes_linkspeed),
		.i_rx_lanes_repair    (i_rx_lanes_repair),
		.o_tx_lanes           (o_tx_lanes),
		.o_rx_lanes           (o_rx_lanes),
		.o_coming_from_repair (o_coming_from_repair)
	);

endmodule

// File: logic/speed_tracker.sv
`timescale 1ns/1ps

module speed_tracker (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                i_load,
	input  logic                i_degrade,
	input  mbtrain_pkg::speed_t i_highest_speed,
	output mbtrain_pkg::speed_t o_speed
);
	import mbtrain_pkg::*;

	// load wins over degrade, the sequencer never sends both
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_speed <= '0;
		end else if (i_load) begin
			o_speed <= i_highest_speed;
		end else if (i_degrade) begin
			// one step down per degrade
			o_speed <= o_speed - speed_t'(1);
		end
	end

	a_no_degrade_at_min: assert property (@(posedge clk) disable iff (!rst_n)
		i_degrade && !i_load |-> o_speed != '0);

endmodule

// File: logic/substate_handshake.sv
`timescale 1ns/1ps

module substate_handshake (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       i_step_start,
	input  mbtrain_pkg::substate_e     i_substate,
	input  mbtrain_pkg::substate_vec_t i_ack,
	output mbtrain_pkg::substate_vec_t o_en,
	output logic                       o_step_done
);
	import mbtrain_pkg::*;

	typedef enum logic [1:0] {
		HS_IDLE,
		HS_WAIT_RISE,
		HS_WAIT_FALL
	} hs_state_e;

	hs_state_e state;
	substate_e sel;
	logic      sel_ack;

	// only the ack of the selected substate counts
	assign sel_ack = i_ack[sel];

	always_ff @(posedge clk) begin
		if (i_step_start) begin
			sel <= i_substate;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= HS_IDLE;
			o_en        <= '0;
			o_step_done <= 1'b0;
		end else begin
			o_step_done <= 1'b0;
			case (state)
				HS_IDLE: begin
					if (i_step_start) begin
						o_en  <= substate_vec_t'(1'b1) << i_substate;
						state <= HS_WAIT_RISE;
					end
				end
				HS_WAIT_RISE: begin
					// drop enable as soon as the substate answers
					if (sel_ack) begin
						o_en  <= '0;
						state <= HS_WAIT_FALL;
					end
				end
				HS_WAIT_FALL: begin
					if (!sel_ack) begin
						o_step_done <= 1'b1;
						state       <= HS_IDLE;
					end
				end
				default: begin
					o_en  <= '0;
					state <= HS_IDLE;
				end
			endcase
		end
	end

	// exactly one enable while waiting for the ack, none otherwise
	a_en_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		(state == HS_WAIT_RISE) ? $onehot(o_en) : (o_en == '0));

	// sequencer must wait for done before the next start
	a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		i_step_start |-> state == HS_IDLE);

endmodule

// File: src.f
logic/mbtrain_pkg.sv
logic/substate_handshake.sv
logic/mbtrain_sequencer.sv
logic/speed_tracker.sv
logic/lane_status.sv
logic/mbtrain_top.sv
test/substate_responder.sv
test/mbtrain_tb.sv

// File: test/mbtrain_tb.sv
`timescale 1ns/1ps

module mbtrain_tb;
	import mbtrain_pkg::*;

	// expected enables per test
	localparam int N_FULL    = 12;
	localparam int N_DEGRADE = 19;
	localparam int N_REPAIR  = 19;
	localparam int N_ENTRY   = 38;
	localparam int WATCHDOG_CYCLES = 40 * (N_FULL + N_DEGRADE + N_REPAIR + N_ENTRY);

	logic                    clk;
	logic                    rst_n;
	logic                    en;
	logic [RESOLVED_W-1:0]   resolved_state;
	logic                    retrain_req;
	logic                    error_req;
	logic                    degrade_req;
	speed_t                  highest_speed;
	lane_halves_t            tx_mbinit;
	lane_halves_t            rx_mbinit;
	lane_halves_t            tx_linkspeed;
	lane_halves_t            rx_repair;
	substate_vec_t           substate_ack;
	substate_vec_t           substate_en;
	substate_e               sideband_substate;
	logic                    phyretrain_en;
	logic                    mbtrain_ack;
	speed_t                  operating_speed;
	lane_halves_t            tx_lanes;
	lane_halves_t            rx_lanes;
	logic                    coming_from_repair;

	// expected state of the outputs
	speed_t                  exp_speed;
	lane_halves_t            exp_tx;
	lane_halves_t            exp_rx;
	logic                    rec_mbinit;
	logic                    rec_train;
	substate_e               exp_q[$];
	substate_vec_t           prev_en;
	int                      mon_idx;

	mbtrain_top dut (
		.clk                  (clk),
		.rst_n                (rst_n),
		.i_en                 (en),
		.i_resolved_state     (resolved_state),
		.i_retrain_req        (retrain_req),
		.i_error_req          (error_req),
		.i_degrade_req        (degrade_req),
		.i_highest_speed      (highest_speed),
		.i_tx_lanes_mbinit    (tx_mbinit),
		.i_rx_lanes_mbinit    (rx_mbinit),
		.i_tx_lanes_linkspeed (tx_linkspeed),
		.i_rx_lanes_repair    (rx_repair),
		.i_substate_ack       (substate_ack),
		.o_substate_en        (substate_en),
		.o_sideband_substate  (sideband_substate),
		.o_phyretrain_en      (phyretrain_en),
		.o_mbtrain_ack        (mbtrain_ack),
		.o_operating_speed    (operating_speed),
		.o_tx_lanes           (tx_lanes),
		.o_rx_lanes           (rx_lanes),
		.o_coming_from_repair (coming_from_repair)
	);

	substate_responder u_responder (
		.clk   (clk),
		.rst_n (rst_n),
		.i_en  (substate_en),
		.o_ack (substate_ack)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("ERROR: %s got 0x%h expected 0x%h", name, got, expected);
			abort_run();
		end
	endtask

	task automatic check_state();
		check_value("o_operating_speed", operating_speed, exp_speed);
		check_value("o_tx_lanes", tx_lanes, exp_tx);
		check_value("o_rx_lanes", rx_lanes, exp_rx);
		check_value("o_coming_from_repair", coming_from_repair, rec_mbinit | rec_train);
	endtask

	task automatic expect_codes(input substate_e first, input substate_e last);
		for (int c = first; c <= last; c++) begin
			exp_q.push_back(substate_e'(c));
		end
	endtask

	task automatic start_training(input logic [RESOLVED_W-1:0] state);
		int cycles;
		resolved_state = state;
		en = 1'b1;
		cycles = 0;
		// i_en is sampled on the first rising edge, the enable comes on the third
		do begin
			@(negedge clk);
			cycles++;
		end while (substate_en == '0 && cycles < 10);
		check_value("first enable latency", cycles, 3);
	endtask

	task automatic wait_for_enable(input substate_e code);
		do begin
			@(negedge clk);
		end while (!substate_en[code]);
	endtask

	task automatic wait_for_ack();
		while (!mbtrain_ack) begin
			@(negedge clk);
		end
		check_value("pending enables", exp_q.size(), 0);
	endtask

	task automatic end_training();
		en = 1'b0;
		@(negedge clk);
		check_value("o_mbtrain_ack", mbtrain_ack, 1'b0);
		@(negedge clk);
		// finish drops the mbinit repair record
		rec_mbinit = 1'b0;
		check_state();
	endtask

	// order of enables, one-hot and sideband code
	always @(negedge clk) begin
		if (!rst_n) begin
			prev_en = '0;
		end else begin
			if ($countones(substate_en) > 1) begin
				$display("more than one substate enable is high");
				abort_run();
			end
			if (substate_en != '0 && prev_en == '0) begin
				mon_idx = 0;
				while (!substate_en[mon_idx]) begin
					mon_idx++;
				end
				if (exp_q.size() == 0) begin
					$display("substate %0d was enabled when none was expected", mon_idx);
					abort_run();
				end
				check_value("o_substate_en order", mon_idx, exp_q.pop_front());
				check_value("o_sideband_substate", sideband_substate, mon_idx);
			end
			prev_en = substate_en;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout after %0d cycles, training did not complete", WATCHDOG_CYCLES);
		abort_run();
	end

	task automatic test_reset_state();
		check_value("o_substate_en", substate_en, '0);
		check_value("o_mbtrain_ack", mbtrain_ack, 1'b0);
		check_value("o_phyretrain_en", phyretrain_en, 1'b0);
		check_state();
	endtask

	task automatic test_full_training();
		highest_speed = 3'd5;
		tx_mbinit = 2'b01;
		rx_mbinit = 2'b11;
		tx_linkspeed = 2'b11;
		exp_speed = highest_speed;
		// link speed exit replaces the mbinit tx set
		exp_tx = tx_linkspeed;
		exp_rx = rx_mbinit;
		rec_mbinit = (tx_mbinit != 2'b11);
		rec_train = 1'b0;
		expect_codes(SS_VALVREF, SS_LINKSPEED);
		start_training(RESOLVED_FULL);
		wait_for_ack();
		check_state();
		end_training();
	endtask

	task automatic test_speed_degrade();
		expect_codes(SS_TX_SELFCAL, SS_LINKSPEED);
		expect_codes(SS_SPEED_IDLE, SS_LINKSPEED);
		start_training(RESOLVED_SELFCAL);
		wait_for_enable(SS_LINKSPEED);
		error_req = 1'b1;
		degrade_req = 1'b1;
		wait_for_enable(SS_SPEED_IDLE);
		exp_speed = exp_speed - 3'd1;
		check_value("o_operating_speed", operating_speed, exp_speed);
		error_req = 1'b0;
		degrade_req = 1'b0;
		wait_for_ack();
		check_state();
		end_training();
	endtask

	task automatic test_repair();
		rx_repair = 2'b10;
		expect_codes(SS_TX_SELFCAL, SS_LINKSPEED);
		expect_codes(SS_REPAIR, SS_REPAIR);
		expect_codes(SS_TX_SELFCAL, SS_LINKSPEED);
		start_training(RESOLVED_SELFCAL);
		wait_for_enable(SS_LINKSPEED);
		error_req = 1'b1;
		wait_for_enable(SS_REPAIR);
		error_req = 1'b0;
		exp_rx = rx_repair;
		rec_train = 1'b1;
		wait_for_ack();
		check_state();
		end_training();
	endtask

	task automatic test_retrain_and_entry();
		expect_codes(SS_TX_SELFCAL, SS_LINKSPEED);
		start_training(RESOLVED_SELFCAL);
		wait_for_enable(SS_LINKSPEED);
		retrain_req = 1'b1;
		wait_for_ack();
		check_value("o_phyretrain_en", phyretrain_en, 1'b1);
		retrain_req = 1'b0;
		end_training();
		check_value("o_phyretrain_en", phyretrain_en, 1'b0);

		expect_codes(SS_TX_SELFCAL, SS_LINKSPEED);
		start_training(RESOLVED_SELFCAL);
		wait_for_ack();
		end_training();

		expect_codes(SS_REPAIR, SS_REPAIR);
		expect_codes(SS_TX_SELFCAL, SS_LINKSPEED);
		start_training(RESOLVED_REPAIR);
		wait_for_ack();
		end_training();

		// degrade entry steps the speed down once
		expect_codes(SS_SPEED_IDLE, SS_LINKSPEED);
		exp_speed = exp_speed - 3'd1;
		start_training(RESOLVED_DEGRADE);
		wait_for_ack();
		check_state();
		end_training();
	endtask

	initial begin
		rst_n = 1'b0;
		en = 1'b0;
		resolved_state = RESOLVED_FULL;
		retrain_req = 1'b0;
		error_req = 1'b0;
		degrade_req = 1'b0;
		highest_speed = '0;
		tx_mbinit = '0;
		rx_mbinit = '0;
		tx_linkspeed = '0;
		rx_repair = '0;
		exp_speed = '0;
		exp_tx = '0;
		exp_rx = '0;
		rec_mbinit = 1'b0;
		rec_train = 1'b0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		test_reset_state();
		test_full_training();
		test_speed_degrade();
		test_repair();
		test_retrain_and_entry();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: test/substate_responder.sv
`timescale 1ns/1ps

module substate_responder (
	input  logic                       clk,
	input  logic                       rst_n,
	input  mbtrain_pkg::substate_vec_t i_en,
	output mbtrain_pkg::substate_vec_t o_ack
);
	import mbtrain_pkg::*;

	logic [15:0] lfsr;
	int          idx;
	int          delay;

	// galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end
		return state >> 1;
	endfunction

	// three bits give 0 to 7 cycles
	task automatic draw_delay(output int cycles);
		cycles = 0;
		repeat (3) begin
			cycles = (cycles << 1) | int'(lfsr[0]);
			lfsr = lfsr_step(lfsr);
		end
	endtask

	initial begin
		lfsr  = 16'd29275;
		o_ack = '0;
		forever begin
			@(negedge clk);
			if (rst_n && i_en != '0) begin
				idx = 0;
				while (!i_en[idx]) begin
					idx++;
				end
				draw_delay(delay);
				repeat (delay) @(negedge clk);
				o_ack[idx] = 1'b1;
				// ack stays up until the enable is gone
				while (i_en[idx]) begin
					@(negedge clk);
				end
				draw_delay(delay);
				repeat (delay) @(negedge clk);
				o_ack[idx] = 1'b0;
			end
		end
	end

endmodule
